// File: source/lookup_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lookup stage definitions
// widths, control header fields, bus structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package lookup_pkg;

    localparam int KEY_W     = 32;
    localparam int PHV_W     = 32;
    localparam int ACT_W     = 64;
    localparam int BEAT_W    = 64;
    localparam int TBL_DEPTH = 16;
    localparam int IDX_W     = 4;

    // address of this stage on the control ring
    localparam logic [4:0]  STAGE_ID  = 5'd1;
    localparam logic [2:0]  LOOKUP_ID = 3'd2;
    localparam logic [15:0] CTRL_FLAG = 16'hf2f1;

    localparam logic [3:0] KIND_TCAM   = 4'h0;
    localparam logic [3:0] KIND_ACTION = 4'h2;

    localparam logic [ACT_W-1:0] DEFAULT_ACTION = 64'h3f;

    typedef struct packed {
        logic [KEY_W-1:0] key;
        logic [KEY_W-1:0] mask;
        logic [PHV_W-1:0] phv;
    } lookup_req_t;

    typedef struct packed {
        logic [ACT_W-1:0] action;
        logic [PHV_W-1:0] phv;
    } lookup_rsp_t;

    // first beat of a control packet
    typedef struct packed {
        logic [4:0]  stage_id;
        logic [2:0]  lookup_id;
        logic [3:0]  kind;
        logic [3:0]  index;
        logic [15:0] flag;
        logic [31:0] pad;
    } ctrl_hdr_t;

    typedef union packed {
        ctrl_hdr_t         hdr;
        logic [BEAT_W-1:0] raw;
    } ctrl_word_u;

    typedef struct packed {
        ctrl_word_u word;
        logic       last;
    } ctrl_beat_t;

    typedef struct packed {
        logic             en;
        logic [IDX_W-1:0] idx;
        logic [ACT_W-1:0] data;
    } tbl_wr_t;

endpackage

`default_nettype wire

// File: source/tcam_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ternary match table, 16 entries
// lowest matching index wins, result registered
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

module tcam_table
    import lookup_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  tbl_wr_t          tcam_wr,
    input  logic [KEY_W-1:0] cmp_key,
    input  logic [KEY_W-1:0] cmp_mask,
    input  logic             cmp_en,
    output logic             hit,
    output logic [IDX_W-1:0] hit_idx
);

    logic [KEY_W-1:0]     entry_key [TBL_DEPTH];
    logic [TBL_DEPTH-1:0] entry_vld;
    logic [TBL_DEPTH-1:0] match;
    logic [IDX_W-1:0]     first_idx;

    always_ff @(posedge clk) begin
        if (tcam_wr.en) begin
            entry_key[tcam_wr.idx] <= tcam_wr.data[KEY_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_vld <= '0;
        end else if (tcam_wr.en) begin
            entry_vld[tcam_wr.idx] <= 1'b1;
        end
    end

    // mask bit set means don't care
    always_comb begin
        first_idx = '0;
        for (int i = 0; i < TBL_DEPTH; i++) begin
            match[i] = entry_vld[i] && (((cmp_key ^ entry_key[i]) & ~cmp_mask) == '0);
        end
        for (int i = TBL_DEPTH - 1; i >= 0; i--) begin
            if (match[i]) begin
                first_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit     <= 1'b0;
            hit_idx <= '0;
        end else if (cmp_en) begin
            hit     <= |match;
            hit_idx <= first_idx;
        end
    end

endmodule

`default_nettype wire

// File: source/action_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// action storage, 16 x 64
// one write port, one registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

module action_ram
    import lookup_pkg::*;
(
    input  logic             clk,
    input  tbl_wr_t          act_wr,
    input  logic             rd_en,
    input  logic [IDX_W-1:0] rd_idx,
    output logic [ACT_W-1:0] rd_data
);

    logic [ACT_W-1:0] mem [TBL_DEPTH];

    always_ff @(posedge clk) begin
        if (act_wr.en) begin
            mem[act_wr.idx] <= act_wr.data;
        end
    end

    // output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: source/lookup_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lookup sequencer
// one request at a time: compare, read, respond
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

module lookup_ctrl
    import lookup_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    input  lookup_req_t      req,
    input  logic             req_valid,
    output logic             req_ready,

    output lookup_rsp_t      rsp,
    output logic             rsp_valid,
    input  logic             rsp_ready,

    output logic [KEY_W-1:0] cmp_key,
    output logic [KEY_W-1:0] cmp_mask,
    output logic             cmp_en,
    input  logic             hit,
    input  logic [IDX_W-1:0] hit_idx,

    output logic             rd_en,
    output logic [IDX_W-1:0] rd_idx,
    input  logic [ACT_W-1:0] rd_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMP,
        ST_READ,
        ST_RESP
    } state_t;

    state_t      state;
    lookup_req_t req_q;

    assign req_ready = (state == ST_IDLE);

    // latched key drives the table for one cycle
    assign cmp_en   = (state == ST_CMP);
    assign cmp_key  = req_q.key;
    assign cmp_mask = req_q.mask;

    // hit result is registered by now, fetch the action
    assign rd_en  = (state == ST_READ) && hit;
    assign rd_idx = hit_idx;

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_READ && !hit) begin
            rsp <= '{action: DEFAULT_ACTION, phv: req_q.phv};
        end else if (state == ST_RESP && !rsp_valid) begin
            rsp <= '{action: rd_data, phv: req_q.phv};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state <= ST_CMP;
                    end
                end
                ST_CMP: begin
                    state <= ST_READ;
                end
                ST_READ: begin
                    // miss answers right away, hit waits one more cycle for ram data
                    state     <= ST_RESP;
                    rsp_valid <= !hit;
                end
                ST_RESP: begin
                    if (!rsp_valid) begin
                        rsp_valid <= 1'b1;
                    end else if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/config_parser.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// control stream parser
// consumes packets for this stage, forwards the rest
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

module config_parser
    import lookup_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  ctrl_beat_t cin,
    input  logic       cin_valid,
    output logic       cin_ready,

    output ctrl_beat_t cout,
    output logic       cout_valid,
    input  logic       cout_ready,

    output tbl_wr_t    tcam_wr,
    output tbl_wr_t    act_wr
);

    typedef enum logic [1:0] {
        ST_HDR,
        ST_DATA,
        ST_DROP,
        ST_PASS
    } state_t;

    state_t           state;
    logic             accept;
    logic             for_us;
    logic             fwd;
    logic [3:0]       kind_q;
    logic [IDX_W-1:0] idx_q;
    logic             wr_tcam;
    logic             wr_act;
    logic [IDX_W-1:0] wr_idx;
    logic [ACT_W-1:0] wr_data;

    // stall only while the output stage is full and blocked
    assign cin_ready = !cout_valid || cout_ready;
    assign accept    = cin_valid && cin_ready;

    assign for_us = (cin.word.hdr.stage_id == STAGE_ID) &&
                    (cin.word.hdr.lookup_id == LOOKUP_ID) &&
                    (cin.word.hdr.flag == CTRL_FLAG);

    // beats of a foreign packet
    assign fwd = accept && ((state == ST_PASS) || (state == ST_HDR && !for_us));

    assign tcam_wr = '{en: wr_tcam, idx: wr_idx, data: wr_data};
    assign act_wr  = '{en: wr_act, idx: wr_idx, data: wr_data};

    always_ff @(posedge clk) begin
        if (accept && state == ST_HDR) begin
            kind_q <= cin.word.hdr.kind;
            idx_q  <= cin.word.hdr.index;
        end
        if (accept && state == ST_DATA) begin
            wr_idx  <= idx_q;
            wr_data <= cin.word.raw;
        end
        if (fwd) begin
            cout <= cin;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_HDR;
            cout_valid <= 1'b0;
            wr_tcam    <= 1'b0;
            wr_act     <= 1'b0;
        end else begin
            wr_tcam <= accept && state == ST_DATA && kind_q == KIND_TCAM;
            wr_act  <= accept && state == ST_DATA && kind_q == KIND_ACTION;

            if (fwd) begin
                cout_valid <= 1'b1;
            end else if (cout_ready) begin
                cout_valid <= 1'b0;
            end

            if (accept) begin
                case (state)
                    ST_HDR: begin
                        if (!cin.last) begin
                            state <= for_us ? ST_DATA : ST_PASS;
                        end
                    end
                    ST_DATA: begin
                        state <= cin.last ? ST_HDR : ST_DROP;
                    end
                    ST_DROP, ST_PASS: begin
                        if (cin.last) begin
                            state <= ST_HDR;
                        end
                    end
                    default: begin
                        state <= ST_HDR;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/lookup_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// match-action lookup stage
// ternary table, action memory, control parser
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

module lookup_engine
    import lookup_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  lookup_req_t req,
    input  logic        req_valid,
    output logic        req_ready,

    output lookup_rsp_t rsp,
    output logic        rsp_valid,
    input  logic        rsp_ready,

    input  ctrl_beat_t  cin,
    input  logic        cin_valid,
    output logic        cin_ready,

    output ctrl_beat_t  cout,
    output logic        cout_valid,
    input  logic        cout_ready
);

    tbl_wr_t          tcam_wr;
    tbl_wr_t          act_wr;
    logic [KEY_W-1:0] cmp_key;
    logic [KEY_W-1:0] cmp_mask;
    logic             cmp_en;
    logic             hit;
    logic [IDX_W-1:0] hit_idx;
    logic             rd_en;
    logic [IDX_W-1:0] rd_idx;
    logic [ACT_W-1:0] rd_data;

    lookup_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .cmp_key   (cmp_key),
        .cmp_mask  (cmp_mask),
        .cmp_en    (cmp_en),
        .hit       (hit),
        .hit_idx   (hit_idx),
        .rd_en     (rd_en),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data)
    );

    tcam_table u_tcam (
        .clk      (clk),
        .rst_n    (rst_n),
        .tcam_wr  (tcam_wr),
        .cmp_key  (cmp_key),
        .cmp_mask (cmp_mask),
        .cmp_en   (cmp_en),
        .hit      (hit),
        .hit_idx  (hit_idx)
    );

    action_ram u_act (
        .clk     (clk),
        .act_wr  (act_wr),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    config_parser u_cfg (
        .clk        (clk),
        .rst_n      (rst_n),
        .cin        (cin),
        .cin_valid  (cin_valid),
        .cin_ready  (cin_ready),
        .cout       (cout),
        .cout_valid (cout_valid),
        .cout_ready (cout_ready),
        .tcam_wr    (tcam_wr),
        .act_wr     (act_wr)
    );

endmodule

`default_nettype wire

// File: bench/lookup_engine_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the match-action lookup stage
// table model, response and forward checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/1ns

module lookup_engine_tb
    import lookup_pkg::*;
();

    localparam int MAX_CYCLES = 3000;

    logic        clk;
    logic        rst_n;
    lookup_req_t req;
    logic        req_valid;
    logic        req_ready;
    lookup_rsp_t rsp;
    logic        rsp_valid;
    logic        rsp_ready;
    ctrl_beat_t  cin;
    logic        cin_valid;
    logic        cin_ready;
    ctrl_beat_t  cout;
    logic        cout_valid;
    logic        cout_ready;

    logic [KEY_W-1:0] m_key [TBL_DEPTH];
    logic             m_vld [TBL_DEPTH];
    logic [ACT_W-1:0] m_act [TBL_DEPTH];

    lookup_rsp_t exp_rsp_q[$];
    ctrl_beat_t  exp_beat_q[$];

    int    cycles = 0;
    int    errors = 0;
    int    checks = 0;
    int    err_mark = 0;
    int    test_no = 1;
    logic  stall_en;

    lookup_engine uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .cin        (cin),
        .cin_valid  (cin_valid),
        .cin_ready  (cin_ready),
        .cout       (cout),
        .cout_valid (cout_valid),
        .cout_ready (cout_ready)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // lowest valid index whose cared-for bits all agree, else the miss action
    function automatic lookup_rsp_t ref_lookup(input lookup_req_t r);
        lookup_rsp_t res;
        logic        found;
        logic        ok;
        res.action = DEFAULT_ACTION;
        res.phv    = r.phv;
        found      = 1'b0;
        for (int i = 0; i < TBL_DEPTH; i++) begin
            ok = m_vld[i];
            for (int b = 0; b < KEY_W; b++) begin
                if (!r.mask[b] && r.key[b] != m_key[i][b]) begin
                    ok = 1'b0;
                end
            end
            if (ok && !found) begin
                res.action = m_act[i];
                found      = 1'b1;
            end
        end
        return res;
    endfunction

    task automatic check_rsp(input lookup_rsp_t got, input lookup_rsp_t exp);
        checks++;
        if (got.action !== exp.action) begin
            errors++;
            $display("error: rsp.action got %h expected %h", got.action, exp.action);
        end
        if (got.phv !== exp.phv) begin
            errors++;
            $display("error: rsp.phv got %h expected %h", got.phv, exp.phv);
        end
    endtask

    task automatic check_beat(input ctrl_beat_t got, input ctrl_beat_t exp);
        checks++;
        if (got.word.raw !== exp.word.raw || got.last !== exp.last) begin
            errors++;
            $display("error: cout got %h/%h expected %h/%h",
                     got.word.raw, got.last, exp.word.raw, exp.last);
        end
    endtask

    // responses and forwarded beats checked at each transfer
    always @(posedge clk) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_rsp_q.size() == 0) begin
                errors++;
                $display("response arrived with no request outstanding");
            end else begin
                check_rsp(rsp, exp_rsp_q.pop_front());
            end
        end
        if (rst_n && cout_valid && cout_ready) begin
            if (exp_beat_q.size() == 0) begin
                errors++;
                $display("control beat forwarded that should have been consumed");
            end else begin
                check_beat(cout, exp_beat_q.pop_front());
            end
        end
    end

    // random back-pressure on both outputs
    always @(negedge clk) begin
        if (stall_en) begin
            if ($urandom % 4 == 0) begin
                rsp_ready = !rsp_ready;
            end
            if ($urandom % 4 == 0) begin
                cout_ready = !cout_ready;
            end
        end else begin
            rsp_ready  = 1'b1;
            cout_ready = 1'b1;
        end
    end

    function automatic lookup_req_t make_req(input logic [31:0] key, input logic [31:0] mask);
        lookup_req_t r;
        r.key  = key;
        r.mask = mask;
        r.phv  = $urandom;
        return r;
    endfunction

    function automatic ctrl_beat_t hdr_beat(input logic [4:0] sid, input logic [2:0] lid,
                                            input logic [3:0] kind, input logic [3:0] idx,
                                            input logic [15:0] flag);
        ctrl_beat_t b;
        b.word.hdr.stage_id  = sid;
        b.word.hdr.lookup_id = lid;
        b.word.hdr.kind      = kind;
        b.word.hdr.index     = idx;
        b.word.hdr.flag      = flag;
        b.word.hdr.pad       = $urandom;
        b.last               = 1'b0;
        return b;
    endfunction

    task automatic send_req(input lookup_req_t r);
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        exp_rsp_q.push_back(ref_lookup(r));
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic send_beat(input ctrl_beat_t b, input logic fwd);
        if (fwd) begin
            exp_beat_q.push_back(b);
        end
        cin       = b;
        cin_valid = 1'b1;
        @(posedge clk);
        while (!cin_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        cin_valid = 1'b0;
    endtask

    task automatic send_cfg(input logic [3:0] kind, input int idx, input logic [63:0] data);
        ctrl_beat_t d;
        d.word.raw = data;
        d.last     = 1'b1;
        send_beat(hdr_beat(STAGE_ID, LOOKUP_ID, kind, 4'(idx), CTRL_FLAG), 1'b0);
        send_beat(d, 1'b0);
        if (kind == KIND_TCAM) begin
            m_key[idx] = data[KEY_W-1:0];
            m_vld[idx] = 1'b1;
        end else begin
            m_act[idx] = data;
        end
    endtask

    // first data beat of a foreign packet carries a key in its low half
    task automatic send_foreign(input ctrl_beat_t h, input logic [31:0] key, input int nbeats);
        ctrl_beat_t d;
        h.last = (nbeats == 0);
        send_beat(h, 1'b1);
        for (int i = 0; i < nbeats; i++) begin
            d.word.raw = {32'($urandom), (i == 0) ? key : 32'($urandom)};
            d.last     = (i == nbeats - 1);
            send_beat(d, 1'b1);
        end
    endtask

    task automatic drain();
        @(negedge clk);
        while (exp_rsp_q.size() != 0 || exp_beat_q.size() != 0 || !req_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
        test_no++;
        err_mark = errors;
    endtask

    initial begin
        logic [31:0] k;
        logic [31:0] m;
        logic [31:0] fk [3];
        int          j;
        void'($urandom(32'h6a54));
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        rsp_ready  = 1'b1;
        cin        = '0;
        cin_valid  = 1'b0;
        cout_ready = 1'b1;
        stall_en   = 1'b0;
        for (int i = 0; i < TBL_DEPTH; i++) begin
            m_vld[i] = 1'b0;
            m_key[i] = '0;
            m_act[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (10) send_req(make_req($urandom, $urandom));
        drain();
        end_test("miss after reset");

        for (int i = 0; i < 8; i++) begin
            send_cfg(KIND_TCAM, i, {32'h0, 32'($urandom)});
            send_cfg(KIND_ACTION, i, {32'($urandom), 32'($urandom)});
        end
        for (int i = 0; i < 8; i++) begin
            send_req(make_req(m_key[i], '0));
        end
        drain();
        end_test("config then exact hit");

        // entries 8 and 9 differ only under the mask
        k = $urandom;
        send_cfg(KIND_TCAM, 9, {32'h0, k ^ 32'h00ff_0000});
        send_cfg(KIND_ACTION, 9, {32'($urandom), 32'($urandom)});
        send_cfg(KIND_TCAM, 8, {32'h0, k});
        send_cfg(KIND_ACTION, 8, {32'($urandom), 32'($urandom)});
        send_req(make_req(k ^ 32'h0055_0000, 32'h00ff_0000));
        for (int n = 0; n < 60; n++) begin
            j = $urandom % 10;
            m = $urandom & $urandom;
            k = ($urandom % 4 == 0) ? 32'($urandom) : (m_key[j] ^ (32'($urandom) & m));
            send_req(make_req(k, m));
        end
        drain();
        end_test("ternary priority and random");

        fk[0] = $urandom;
        fk[1] = $urandom;
        fk[2] = $urandom;
        send_foreign(hdr_beat(STAGE_ID + 5'd1, LOOKUP_ID, KIND_TCAM, 4'd15, CTRL_FLAG), fk[0], 2);
        send_foreign(hdr_beat(STAGE_ID, LOOKUP_ID + 3'd1, KIND_TCAM, 4'd15, CTRL_FLAG), fk[1], 1);
        send_foreign(hdr_beat(STAGE_ID, LOOKUP_ID, KIND_TCAM, 4'd15, 16'hf2f0), fk[2], 3);
        drain();
        for (int i = 0; i < 3; i++) begin
            send_req(make_req(fk[i], '0));
        end
        drain();
        end_test("foreign packets forwarded");

        stall_en = 1'b1;
        fork
            repeat (30) begin
                j = $urandom % 10;
                send_req(make_req(m_key[j], 32'($urandom) & 32'h0000_00ff));
            end
            repeat (8) begin
                send_foreign(hdr_beat(5'($urandom) | 5'd16, 3'($urandom), 4'($urandom),
                                      4'($urandom), 16'($urandom)), $urandom, $urandom % 4);
            end
        join
        drain();
        stall_en = 1'b0;
        end_test("back-pressure");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lookup_engine.f
source/lookup_pkg.sv
source/tcam_table.sv
source/action_ram.sv
source/lookup_ctrl.sv
source/config_parser.sv
source/lookup_engine.sv
bench/lookup_engine_tb.sv
